/* include/vcore_consts.svh */
// assumes a 32-bit datapath with RV32I encodings; the program must keep every address word aligned
`ifndef VCORE_CONSTS_SVH
`define VCORE_CONSTS_SVH

// ----------------------------------------
// widths
`define XLEN            32
`define ADDR_WIDTH      16
`define REG_COUNT       32
`define REG_INDEX_WIDTH 5

// program counter
`define PC_STEP         4
`define RESET_PC        0

// ----------------------------------------
// opcodes of the kept subset
`define OPC_OP          7'b0110011
`define OPC_OP_IMM      7'b0010011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_BRANCH      7'b1100011
`define OPC_JAL         7'b1101111

// funct3 and funct7 values
`define FUNCT3_BEQ      3'b000
`define FUNCT3_BNE      3'b001
`define FUNCT3_ADD      3'b000
`define FUNCT3_XOR      3'b100
`define FUNCT3_OR       3'b110
`define FUNCT3_AND      3'b111
`define FUNCT3_WORD     3'b010
`define FUNCT7_SUB      7'b0100000

`endif

/* design/isa_pkg.sv */
// instruction and data types; alu, write-back and branch codes are internal to the core
`include "vcore_consts.svh"

package isa_pkg;

    // ----------------------------------------
    // architectural data
    typedef logic [`XLEN-1:0]            word_t;
    typedef logic [`REG_INDEX_WIDTH-1:0] reg_index_t;

    // ----------------------------------------
    // decoded controls

    // alu operation
    typedef logic [2:0] alu_op_t;
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;

    // source of the register write, none means no write
    typedef logic [1:0] wb_sel_t;
    localparam wb_sel_t WB_NONE = 2'd0;
    localparam wb_sel_t WB_ALU  = 2'd1;
    localparam wb_sel_t WB_LOAD = 2'd2;
    localparam wb_sel_t WB_LINK = 2'd3;

    // branch class
    typedef logic [1:0] branch_kind_t;
    localparam branch_kind_t BR_NONE = 2'd0;
    localparam branch_kind_t BR_EQ   = 2'd1;
    localparam branch_kind_t BR_NE   = 2'd2;
    localparam branch_kind_t BR_JUMP = 2'd3;

endpackage

/* design/core_ctrl_pkg.sv */
// stage sequencing and bus request types; only one instruction is ever in flight
`include "vcore_consts.svh"

package core_ctrl_pkg;

    // ----------------------------------------
    // stage controller, values run in stage order
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } stage_t;

    // ----------------------------------------
    // bus side
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    typedef logic [1:0] bus_req_t;
    localparam bus_req_t REQ_FETCH = 2'd0;
    localparam bus_req_t REQ_LOAD  = 2'd1;
    localparam bus_req_t REQ_STORE = 2'd2;

endpackage

/* design/instr_decoder.sv */
// combinational decoder for the kept RV32I subset; anything else decodes as a no-op
`include "vcore_consts.svh"

module instr_decoder (
    input  isa_pkg::word_t        instr,
    output isa_pkg::reg_index_t   rs1,
    output isa_pkg::reg_index_t   rs2,
    output isa_pkg::reg_index_t   rd,
    output isa_pkg::word_t        imm,
    output isa_pkg::alu_op_t      alu_op,
    output logic                  use_imm,
    output logic                  mem_read,
    output logic                  mem_write,
    output isa_pkg::branch_kind_t branch_kind,
    output isa_pkg::wb_sel_t      wb_sel
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    always_comb begin
        // defaults give a no-op
        imm         = '0;
        alu_op      = isa_pkg::ALU_ADD;
        use_imm     = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        branch_kind = isa_pkg::BR_NONE;
        wb_sel      = isa_pkg::WB_NONE;

        case (opcode)
            `OPC_OP: begin
                wb_sel = isa_pkg::WB_ALU;
                if (funct3 == `FUNCT3_ADD && funct7 == `FUNCT7_SUB) begin
                    alu_op = isa_pkg::ALU_SUB;
                end else if (funct7 != '0) begin
                    wb_sel = isa_pkg::WB_NONE;
                end else begin
                    case (funct3)
                        `FUNCT3_ADD: alu_op = isa_pkg::ALU_ADD;
                        `FUNCT3_XOR: alu_op = isa_pkg::ALU_XOR;
                        `FUNCT3_OR:  alu_op = isa_pkg::ALU_OR;
                        `FUNCT3_AND: alu_op = isa_pkg::ALU_AND;
                        default:     wb_sel = isa_pkg::WB_NONE;
                    endcase
                end
            end
            `OPC_OP_IMM: begin
                // addi only
                imm     = {{20{instr[31]}}, instr[31:20]};
                use_imm = 1'b1;
                if (funct3 == `FUNCT3_ADD) begin
                    wb_sel = isa_pkg::WB_ALU;
                end
            end
            `OPC_LOAD: begin
                imm     = {{20{instr[31]}}, instr[31:20]};
                use_imm = 1'b1;
                if (funct3 == `FUNCT3_WORD) begin
                    mem_read = 1'b1;
                    wb_sel   = isa_pkg::WB_LOAD;
                end
            end
            `OPC_STORE: begin
                imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                use_imm   = 1'b1;
                mem_write = (funct3 == `FUNCT3_WORD);
            end
            `OPC_BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                if (funct3 == `FUNCT3_BEQ) begin
                    branch_kind = isa_pkg::BR_EQ;
                end else if (funct3 == `FUNCT3_BNE) begin
                    branch_kind = isa_pkg::BR_NE;
                end
            end
            `OPC_JAL: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
                branch_kind = isa_pkg::BR_JUMP;
                wb_sel      = isa_pkg::WB_LINK;
            end
            default: begin
                wb_sel = isa_pkg::WB_NONE;
            end
        endcase
    end

endmodule

/* design/scalar_register_file.sv */
// two asynchronous read ports, one write port on the clock edge; x0 is never written
`include "vcore_consts.svh"

module scalar_register_file (
    input  logic                clk,
    input  logic                rst,
    input  isa_pkg::reg_index_t rs1,
    input  isa_pkg::reg_index_t rs2,
    input  isa_pkg::reg_index_t rd,
    input  isa_pkg::word_t      wdata,
    input  logic                we,
    output isa_pkg::word_t      rs1_data,
    output isa_pkg::word_t      rs2_data
);

    isa_pkg::word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // read during decode
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // ----------------------------------------
    // checks

    // x0 survives every write-back
    a_x0_zero: assert property (
        @(posedge clk) disable iff (!rst)
        we |=> (regs[0] == '0)
    );

endmodule

/* design/scalar_alu.sv */
// purely combinational; add and sub wrap at XLEN, equal feeds the branch decision
module scalar_alu (
    input  isa_pkg::word_t   a,
    input  isa_pkg::word_t   b,
    input  isa_pkg::alu_op_t op,
    output isa_pkg::word_t   result,
    output logic             equal
);

    isa_pkg::word_t sum;
    isa_pkg::word_t diff;

    // carry and borrow dropped
    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (op)
            isa_pkg::ALU_ADD: begin
                result = sum;
            end
            isa_pkg::ALU_SUB: begin
                result = diff;
            end
            isa_pkg::ALU_AND: begin
                result = a & b;
            end
            isa_pkg::ALU_OR: begin
                result = a | b;
            end
            isa_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // beq and bne compare the two register operands
    assign equal = (a == b);

endmodule

/* design/wb_bus_master.sv */
// Wishbone classic master, one cycle per req; req must not arrive while a cycle is open
module wb_bus_master (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  core_ctrl_pkg::bus_req_t req_kind,
    input  core_ctrl_pkg::addr_t    addr,
    input  isa_pkg::word_t          wdata,
    output logic                    done,
    output isa_pkg::word_t          rdata,
    output logic                    cyc,
    output logic                    stb,
    output logic                    we,
    output core_ctrl_pkg::addr_t    adr,
    output isa_pkg::word_t          dat_w,
    input  isa_pkg::word_t          dat_r,
    input  logic                    ack
);

    // ----------------------------------------
    // cycle control
    always_ff @(posedge clk) begin
        if (!rst) begin
            cyc  <= 1'b0;
            stb  <= 1'b0;
            we   <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (req) begin
                cyc <= 1'b1;
                stb <= 1'b1;
                we  <= (req_kind == core_ctrl_pkg::REQ_STORE);
            end else if (cyc && ack) begin
                // close on the edge that samples ack
                cyc  <= 1'b0;
                stb  <= 1'b0;
                we   <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // address and data held until ack
    always_ff @(posedge clk) begin
        if (req) begin
            adr   <= addr;
            dat_w <= wdata;
        end
        if (cyc && ack) begin
            rdata <= dat_r;
        end
    end

    // ----------------------------------------
    // checks
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst) stb |-> cyc);

    a_adr_aligned: assert property (
        @(posedge clk) disable iff (!rst)
        stb |-> (adr[1:0] == 2'b00)
    );

    // the stage controller waits for done before asking again
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst) req |-> !cyc);

endmodule

/* design/core_top.sv */
// one instruction in flight, no forwarding; fetch and data share the single Wishbone master
`include "vcore_consts.svh"

module core_top (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 cyc,
    output logic                 stb,
    output logic                 we,
    output core_ctrl_pkg::addr_t adr,
    output isa_pkg::word_t       dat_w,
    input  isa_pkg::word_t       dat_r,
    input  logic                 ack
);

    // ----------------------------------------
    // stage and architectural state
    core_ctrl_pkg::stage_t   state;
    isa_pkg::word_t          pc;
    isa_pkg::word_t          ir;
    logic                    bus_req;

    // decode to execute
    isa_pkg::word_t          ex_a;
    isa_pkg::word_t          ex_b;
    isa_pkg::word_t          ex_store;
    isa_pkg::word_t          ex_imm;
    isa_pkg::reg_index_t     ex_rd;
    isa_pkg::alu_op_t        ex_alu_op;
    logic                    ex_mem_read;
    logic                    ex_mem_write;
    isa_pkg::branch_kind_t   ex_branch;
    isa_pkg::wb_sel_t        ex_wb_sel;

    // execute to memory and write-back
    isa_pkg::word_t          mem_result;
    logic                    mem_equal;
    isa_pkg::word_t          load_data;

    // block outputs
    isa_pkg::reg_index_t     dec_rs1;
    isa_pkg::reg_index_t     dec_rs2;
    isa_pkg::reg_index_t     dec_rd;
    isa_pkg::word_t          dec_imm;
    isa_pkg::alu_op_t        dec_alu_op;
    logic                    dec_use_imm;
    logic                    dec_mem_read;
    logic                    dec_mem_write;
    isa_pkg::branch_kind_t   dec_branch;
    isa_pkg::wb_sel_t        dec_wb_sel;
    isa_pkg::word_t          rf_rs1_data;
    isa_pkg::word_t          rf_rs2_data;
    isa_pkg::word_t          alu_result;
    logic                    alu_equal;
    logic                    bus_done;
    isa_pkg::word_t          bus_rdata;

    // glue
    logic                    mem_access;
    core_ctrl_pkg::bus_req_t bus_kind;
    core_ctrl_pkg::addr_t    bus_addr;
    logic                    branch_taken;
    isa_pkg::word_t          link_pc;
    isa_pkg::word_t          next_pc;
    isa_pkg::word_t          wb_data;
    logic                    rf_we;

    instr_decoder decoder_i (
        .instr       (ir),
        .rs1         (dec_rs1),
        .rs2         (dec_rs2),
        .rd          (dec_rd),
        .imm         (dec_imm),
        .alu_op      (dec_alu_op),
        .use_imm     (dec_use_imm),
        .mem_read    (dec_mem_read),
        .mem_write   (dec_mem_write),
        .branch_kind (dec_branch),
        .wb_sel      (dec_wb_sel)
    );

    scalar_register_file regfile_i (
        .clk      (clk),
        .rst      (rst),
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .rd       (ex_rd),
        .wdata    (wb_data),
        .we       (rf_we),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data)
    );

    scalar_alu alu_i (
        .a      (ex_a),
        .b      (ex_b),
        .op     (ex_alu_op),
        .result (alu_result),
        .equal  (alu_equal)
    );

    wb_bus_master bus_i (
        .clk      (clk),
        .rst      (rst),
        .req      (bus_req),
        .req_kind (bus_kind),
        .addr     (bus_addr),
        .wdata    (ex_store),
        .done     (bus_done),
        .rdata    (bus_rdata),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .dat_w    (dat_w),
        .dat_r    (dat_r),
        .ack      (ack)
    );

    // ----------------------------------------
    // stage controller
    assign mem_access = ex_mem_read || ex_mem_write;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= core_ctrl_pkg::FETCH;
            pc      <= `RESET_PC;
            bus_req <= 1'b1;
        end else begin
            bus_req <= 1'b0;
            case (state)
                core_ctrl_pkg::FETCH: begin
                    if (bus_done) begin
                        state <= core_ctrl_pkg::DECODE;
                    end
                end
                core_ctrl_pkg::DECODE: begin
                    state <= core_ctrl_pkg::EXECUTE;
                end
                core_ctrl_pkg::EXECUTE: begin
                    state   <= core_ctrl_pkg::MEMORY;
                    bus_req <= mem_access;
                end
                core_ctrl_pkg::MEMORY: begin
                    if (!mem_access || bus_done) begin
                        state <= core_ctrl_pkg::WRITEBACK;
                    end
                end
                core_ctrl_pkg::WRITEBACK: begin
                    state   <= core_ctrl_pkg::FETCH;
                    pc      <= next_pc;
                    bus_req <= 1'b1;
                end
                default: begin
                    state <= core_ctrl_pkg::FETCH;
                end
            endcase
        end
    end

    // stage registers, each written only in its own stage
    always_ff @(posedge clk) begin
        if (state == core_ctrl_pkg::FETCH && bus_done) begin
            ir <= bus_rdata;
        end
        if (state == core_ctrl_pkg::DECODE) begin
            ex_a         <= rf_rs1_data;
            ex_b         <= dec_use_imm ? dec_imm : rf_rs2_data;
            ex_store     <= rf_rs2_data;
            ex_imm       <= dec_imm;
            ex_rd        <= dec_rd;
            ex_alu_op    <= dec_alu_op;
            ex_mem_read  <= dec_mem_read;
            ex_mem_write <= dec_mem_write;
            ex_branch    <= dec_branch;
            ex_wb_sel    <= dec_wb_sel;
        end
        if (state == core_ctrl_pkg::EXECUTE) begin
            mem_result <= alu_result;
            mem_equal  <= alu_equal;
        end
        if (state == core_ctrl_pkg::MEMORY && bus_done) begin
            load_data <= bus_rdata;
        end
    end

    // ----------------------------------------
    // bus request contents
    assign bus_kind = (state == core_ctrl_pkg::FETCH) ? core_ctrl_pkg::REQ_FETCH :
                      ex_mem_write ? core_ctrl_pkg::REQ_STORE : core_ctrl_pkg::REQ_LOAD;
    assign bus_addr = (state == core_ctrl_pkg::FETCH) ? pc[`ADDR_WIDTH-1:0]
                                                      : mem_result[`ADDR_WIDTH-1:0];

    // next pc
    always_comb begin
        case (ex_branch)
            isa_pkg::BR_EQ:   branch_taken = mem_equal;
            isa_pkg::BR_NE:   branch_taken = !mem_equal;
            isa_pkg::BR_JUMP: branch_taken = 1'b1;
            default:          branch_taken = 1'b0;
        endcase
    end

    assign link_pc = pc + `PC_STEP;
    assign next_pc = branch_taken ? (pc + ex_imm) : link_pc;

    // write-back source
    always_comb begin
        case (ex_wb_sel)
            isa_pkg::WB_ALU:  wb_data = mem_result;
            isa_pkg::WB_LOAD: wb_data = load_data;
            isa_pkg::WB_LINK: wb_data = link_pc;
            default:          wb_data = '0;
        endcase
    end

    assign rf_we = (state == core_ctrl_pkg::WRITEBACK) && (ex_wb_sel != isa_pkg::WB_NONE);

    // ----------------------------------------
    // checks

    // stages advance one step at a time and wrap from write-back to fetch
    a_stage_order: assert property (
        @(posedge clk) disable iff (!rst)
        (state != $past(state)) |->
            (state == (($past(state) == core_ctrl_pkg::WRITEBACK) ? core_ctrl_pkg::FETCH
                       : core_ctrl_pkg::stage_t'($past(state) + 3'd1)))
    );

endmodule

/* bench/wb_memory_model.sv */
// word-wide Wishbone classic slave; addresses alias every DEPTH words, 0 to 3 wait states per cycle
module wb_memory_model #(
    parameter int DEPTH     = 1024,
    parameter int ACK_DELAY = 10
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  core_ctrl_pkg::addr_t adr,
    input  isa_pkg::word_t       dat_w,
    output isa_pkg::word_t       dat_r,
    output logic                 ack
);

    isa_pkg::word_t           mem [DEPTH];
    integer                   seed;
    int                       wait_left;
    logic                     busy;
    logic [$clog2(DEPTH)-1:0] index;

    assign index = adr[$clog2(DEPTH)+1:2];

    initial begin
        seed      = 32'he787f2fe;
        busy      = 1'b0;
        wait_left = 0;
        ack       = 1'b0;
        dat_r     = '0;
    end

    // ----------------------------------------
    // one transfer per open cycle
    always @(posedge clk) begin
        if (!rst) begin
            busy = 1'b0;
            ack <= #ACK_DELAY 1'b0;
        end else if (ack) begin
            // master sees ack on this edge and closes the cycle
            busy = 1'b0;
            ack <= #ACK_DELAY 1'b0;
        end else if (cyc && stb) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = $random(seed) & 3;
            end
            if (wait_left == 0) begin
                if (we) begin
                    mem[index] = dat_w;
                end
                dat_r <= #ACK_DELAY mem[index];
                ack   <= #ACK_DELAY 1'b1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

endmodule

/* bench/core_tb.sv */
// runs a fixed program on core_top and checks every store in order; stops at the first mismatch
`include "vcore_consts.svh"

module core_tb;

    localparam int HALF_PERIOD   = 50;
    localparam int DRIVE_DELAY   = 10;
    localparam int RESET_CYCLES  = 16;
    localparam int STORE_TIMEOUT = 500;
    localparam int MEM_DEPTH     = 1024;
    localparam int PROG_LEN      = 30;
    localparam int NUM_STORES    = 9;
    localparam core_ctrl_pkg::addr_t END_ADDR = 16'h0ffc;

    logic                 clk;
    logic                 rst;
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic                 ack;
    core_ctrl_pkg::addr_t adr;
    isa_pkg::word_t       dat_w;
    isa_pkg::word_t       dat_r;

    isa_pkg::word_t       prog     [PROG_LEN];
    core_ctrl_pkg::addr_t exp_addr [NUM_STORES];
    isa_pkg::word_t       exp_data [NUM_STORES];

    core_top dut_i (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    wb_memory_model #(
        .DEPTH     (MEM_DEPTH),
        .ACK_DELAY (DRIVE_DELAY)
    ) mem_i (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // ----------------------------------------
    // RV32I encodings
    function automatic isa_pkg::word_t alu_reg_instr(input logic [6:0] funct7,
            input logic [2:0] funct3, input isa_pkg::reg_index_t rd,
            input isa_pkg::reg_index_t rs1, input isa_pkg::reg_index_t rs2);
        return {funct7, rs2, rs1, funct3, rd, `OPC_OP};
    endfunction

    function automatic isa_pkg::word_t imm_instr(input logic [6:0] opcode,
            input logic [2:0] funct3, input isa_pkg::reg_index_t rd,
            input isa_pkg::reg_index_t rs1, input logic [11:0] imm);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic isa_pkg::word_t store_instr(input isa_pkg::reg_index_t rs2,
            input isa_pkg::reg_index_t rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, `FUNCT3_WORD, imm[4:0], `OPC_STORE};
    endfunction

    function automatic isa_pkg::word_t branch_instr(input logic [2:0] funct3,
            input isa_pkg::reg_index_t rs1, input isa_pkg::reg_index_t rs2,
            input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic isa_pkg::word_t jump_instr(input isa_pkg::reg_index_t rd,
            input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    // ----------------------------------------
    // program and expected stores
    task automatic load_program();
        // x10 holds the store base 0x700
        prog[0]  = imm_instr(`OPC_OP_IMM, `FUNCT3_ADD, 5'd10, 5'd0, 12'h700);
        prog[1]  = imm_instr(`OPC_OP_IMM, `FUNCT3_ADD, 5'd1, 5'd0, 12'h7ff);
        prog[2]  = imm_instr(`OPC_OP_IMM, `FUNCT3_ADD, 5'd2, 5'd0, 12'hfff);
        prog[3]  = alu_reg_instr(7'd0, `FUNCT3_ADD, 5'd3, 5'd1, 5'd2);
        prog[4]  = store_instr(5'd3, 5'd10, 12'd0);
        prog[5]  = alu_reg_instr(`FUNCT7_SUB, `FUNCT3_ADD, 5'd4, 5'd0, 5'd1);
        prog[6]  = store_instr(5'd4, 5'd10, 12'd4);
        prog[7]  = alu_reg_instr(7'd0, `FUNCT3_XOR, 5'd6, 5'd4, 5'd1);
        prog[8]  = store_instr(5'd6, 5'd10, 12'd8);
        prog[9]  = alu_reg_instr(7'd0, `FUNCT3_AND, 5'd7, 5'd4, 5'd1);
        prog[10] = store_instr(5'd7, 5'd10, 12'd12);
        prog[11] = alu_reg_instr(7'd0, `FUNCT3_OR, 5'd8, 5'd6, 5'd1);
        prog[12] = store_instr(5'd8, 5'd10, 12'd16);
        prog[13] = imm_instr(`OPC_LOAD, `FUNCT3_WORD, 5'd9, 5'd10, 12'd4);
        prog[14] = store_instr(5'd9, 5'd10, 12'd20);
        // taken beq and bne each skip one store
        prog[15] = branch_instr(`FUNCT3_BEQ, 5'd1, 5'd1, 13'd8);
        prog[16] = store_instr(5'd2, 5'd10, 12'd24);
        prog[17] = branch_instr(`FUNCT3_BNE, 5'd1, 5'd1, 13'd8);
        prog[18] = store_instr(5'd1, 5'd10, 12'd28);
        prog[19] = branch_instr(`FUNCT3_BNE, 5'd1, 5'd2, 13'd8);
        prog[20] = store_instr(5'd2, 5'd10, 12'd32);
        prog[21] = jump_instr(5'd12, 21'd8);
        prog[22] = store_instr(5'd2, 5'd10, 12'd36);
        prog[23] = store_instr(5'd12, 5'd10, 12'd40);
        prog[24] = imm_instr(`OPC_OP_IMM, `FUNCT3_ADD, 5'd0, 5'd0, 12'h123);
        prog[25] = store_instr(5'd0, 5'd10, 12'd44);
        // end marker at 0xffc and a spin loop
        prog[26] = imm_instr(`OPC_OP_IMM, `FUNCT3_ADD, 5'd11, 5'd0, 12'h7fe);
        prog[27] = alu_reg_instr(7'd0, `FUNCT3_ADD, 5'd11, 5'd11, 5'd11);
        prog[28] = store_instr(5'd1, 5'd11, 12'd0);
        prog[29] = jump_instr(5'd0, 21'd0);

        // unused words carry an address-dependent pattern
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem_i.mem[i] = 32'hdead_0000 ^ (i << 2);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            mem_i.mem[i] = prog[i];
        end

        exp_addr = '{16'h0700, 16'h0704, 16'h0708, 16'h070c, 16'h0710,
                     16'h0714, 16'h071c, 16'h0728, 16'h072c};
        // 0x7ff + -1, 0 - 0x7ff, x4 ^ 0x7ff, x4 & 0x7ff, x6 | 0x7ff, loaded word,
        // bne fall-through, jal link and x0
        exp_data = '{32'h0000_07fe, 32'hffff_f801, 32'hffff_fffe, 32'h0000_0001,
                     32'hffff_ffff, 32'hffff_f801, 32'h0000_07ff, 32'h0000_0058,
                     32'h0000_0000};
    endtask

    // ----------------------------------------
    // store monitor sampled at the falling edge
    task automatic wait_for_store(input int number, output core_ctrl_pkg::addr_t addr,
            output isa_pkg::word_t data);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < STORE_TIMEOUT) begin
            @(negedge clk);
            if (cyc && stb && we && ack) begin
                seen = 1'b1;
                addr = adr;
                data = dat_w;
            end
            cycles++;
        end
        assert (seen) else begin
            $display("timeout: store %0d was not acknowledged within %0d cycles",
                     number, STORE_TIMEOUT);
            $display("=== FAIL ===");
            $fatal(1, "store wait expired");
        end
    endtask

    initial begin
        core_ctrl_pkg::addr_t got_addr;
        isa_pkg::word_t       got_data;

        rst = 1'b0;
        load_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b1;

        for (int n = 0; n < NUM_STORES; n++) begin
            wait_for_store(n, got_addr, got_data);
            assert (got_addr == exp_addr[n]) else begin
                $display("CHECK FAILED adr store %0d: expected %h, got %h",
                         n, exp_addr[n], got_addr);
                $display("=== FAIL ===");
                $fatal(1, "store address mismatch");
            end
            assert (got_data == exp_data[n]) else begin
                $display("CHECK FAILED dat_w store %0d: expected %h, got %h",
                         n, exp_data[n], got_data);
                $display("=== FAIL ===");
                $fatal(1, "store data mismatch");
            end
        end

        wait_for_store(NUM_STORES, got_addr, got_data);
        assert (got_addr == END_ADDR) else begin
            $display("CHECK FAILED adr end marker: expected %h, got %h", END_ADDR, got_addr);
            $display("=== FAIL ===");
            $fatal(1, "unexpected extra store");
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* vcore_lite.f */
+incdir+include
design/isa_pkg.sv
design/core_ctrl_pkg.sv
design/instr_decoder.sv
design/scalar_register_file.sv
design/scalar_alu.sv
design/wb_bus_master.sv
design/core_top.sv
bench/wb_memory_model.sv
bench/core_tb.sv

/* Bender.yml */
package:
  name: vcore_lite

export_include_dirs:
  - include

sources:
  - design/isa_pkg.sv
  - design/core_ctrl_pkg.sv
  - design/instr_decoder.sv
  - design/scalar_register_file.sv
  - design/scalar_alu.sv
  - design/wb_bus_master.sv
  - design/core_top.sv
  - target: simulation
    files:
      - bench/wb_memory_model.sv
      - bench/core_tb.sv
